// ==== rtl/nand_pkg.sv ====
//----------------------------
// Shared definitions of the ONFI NAND master, x8 bus only
// Timing counts are in clk cycles and must be scaled to the clock rate
//----------------------------
package nand_pkg;

	//----------------------------
	// Host opcodes, driven on cmd_in
	//----------------------------
	typedef enum logic [5:0] {
		OP_NAND_RESET     = 6'h01,
		OP_READ_STATUS    = 6'h02,
		OP_READ_ID        = 6'h03,
		OP_GET_STATUS     = 6'h08,
		OP_CHIP_ENABLE    = 6'h09,
		OP_CHIP_DISABLE   = 6'h0a,
		OP_WRITE_PROTECT  = 6'h0b,
		OP_WRITE_ENABLE   = 6'h0c,
		OP_RESET_INDEX    = 6'h0d,
		OP_GET_ID_BYTE    = 6'h0e,
		OP_BYPASS_COMMAND = 6'h10,
		OP_BYPASS_ADDRESS = 6'h11,
		OP_BYPASS_DATA_WR = 6'h12,
		OP_BYPASS_DATA_RD = 6'h13
	} host_op_t;

	// Kind of one latched write cycle on the bus
	typedef enum logic [1:0] {
		CYC_CMD  = 2'd0,
		CYC_ADDR = 2'd1,
		CYC_DATA = 2'd2
	} cycle_kind_t;

	// Sequencer states
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_REG     = 3'd1,
		S_WRITE   = 3'd2,
		S_WR_WAIT = 3'd3,
		S_DELAY   = 3'd4,
		S_RNB     = 3'd5,
		S_READ    = 3'd6,
		S_RD_WAIT = 3'd7
	} seq_state_t;

	//----------------------------
	// NAND command bytes
	//----------------------------
	localparam logic [7:0] NAND_CMD_RESET       = 8'hff;
	localparam logic [7:0] NAND_CMD_READ_STATUS = 8'h70;
	localparam logic [7:0] NAND_CMD_READ_ID     = 8'h90;

	// Length of the JEDEC ID read by READ ID
	localparam int ID_BYTES = 5;

	// Pulse phases of one WE# or RE# cycle
	localparam int T_WE_LOW  = 2;
	localparam int T_WE_HIGH = 2;
	localparam int T_RE_LOW  = 2;
	localparam int T_RE_HIGH = 2;

	// tWB before R/B# is valid, tWHR before the first data read
	localparam logic [3:0] T_WB  = 4'd4;
	localparam logic [3:0] T_WHR = 4'd6;

	// Status register bits, 1 means true
	localparam int ST_CHIP_EN    = 2;
	localparam int ST_WRITE_PROT = 3;
	localparam int ST_INDEX_ERR  = 4;

	// Chip disabled and write protected out of reset
	localparam logic [7:0] STATUS_RESET = 8'h08;

endpackage

// ==== rtl/nand_write_cycle.sv ====
//----------------------------
// One latched write cycle: CLE, ALE or data, strobed by WE#
// start must not come before the previous done
//----------------------------
module nand_write_cycle (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  start,
	input  nand_pkg::cycle_kind_t kind,
	input  logic [7:0]            data,
	output logic                  done,
	output logic                  cle,
	output logic                  ale,
	output logic                  nwe,
	output logic [7:0]            dq_out,
	output logic                  dq_oe
);

	// Whole cycle length and the count of the last clock
	localparam int CYC_LEN = nand_pkg::T_WE_LOW + nand_pkg::T_WE_HIGH;
	localparam logic [2:0] LAST_CNT = 3'(CYC_LEN - 1);
	localparam logic [2:0] LOW_END = 3'(nand_pkg::T_WE_LOW - 1);

	logic       active;
	logic [2:0] phase;

	// Phase counter and pin levels
	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase  <= '0;
			cle    <= 1'b0;
			ale    <= 1'b0;
			nwe    <= 1'b1;
			dq_oe  <= 1'b0;
		end else if (start) begin
			// Latch enables are held for the whole cycle
			active <= 1'b1;
			phase  <= '0;
			cle    <= (kind == nand_pkg::CYC_CMD);
			ale    <= (kind == nand_pkg::CYC_ADDR);
			nwe    <= 1'b0;
			dq_oe  <= 1'b1;
		end else if (active) begin
			phase <= phase + 3'd1;
			// Rising WE# is where the chip latches the byte
			if (phase == LOW_END)
				nwe <= 1'b1;
			if (phase == LAST_CNT) begin
				active <= 1'b0;
				cle    <= 1'b0;
				ale    <= 1'b0;
				dq_oe  <= 1'b0;
			end
		end
	end

	// Byte on the bus, held until the next start
	always_ff @(posedge clk) begin
		if (start)
			dq_out <= data;
	end

	// End of the high phase
	assign done = active && (phase == LAST_CNT);

endmodule

// ==== rtl/nand_read_cycle.sv ====
//----------------------------
// One RE# read cycle, byte sampled on the last low clock
// start must not come before the previous done
//----------------------------
module nand_read_cycle (
	input  logic       clk,
	input  logic       nreset,
	input  logic       start,
	input  logic [7:0] dq_in,
	output logic       done,
	output logic       nre,
	output logic [7:0] data
);

	localparam int CYC_LEN = nand_pkg::T_RE_LOW + nand_pkg::T_RE_HIGH;
	localparam logic [2:0] LAST_CNT = 3'(CYC_LEN - 1);
	localparam logic [2:0] LOW_END = 3'(nand_pkg::T_RE_LOW - 1);

	logic       active;
	logic [2:0] phase;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase  <= '0;
			nre    <= 1'b1;
		end else if (start) begin
			active <= 1'b1;
			phase  <= '0;
			nre    <= 1'b0;
		end else if (active) begin
			phase <= phase + 3'd1;
			if (phase == LOW_END)
				nre <= 1'b1;
			if (phase == LAST_CNT)
				active <= 1'b0;
		end
	end

	// Sample while RE# is still low, chip output has settled by then
	always_ff @(posedge clk) begin
		if (active && (phase == LOW_END))
			data <= dq_in;
	end

	assign done = active && (phase == LAST_CNT);

endmodule

// ==== rtl/nand_sequencer.sv ====
//----------------------------
// Host command interpreter and NAND operation FSM
// activate is ignored while busy is high
// A stuck-low R/B# stalls NAND RESET forever
//----------------------------
module nand_sequencer (
	input  logic                  clk,
	input  logic                  nreset,
	input  logic                  activate,
	input  nand_pkg::host_op_t    cmd_in,
	input  logic [7:0]            data_in,
	output logic [7:0]            data_out,
	output logic                  busy,
	output logic                  nce,
	output logic                  nwp,
	input  logic                  rnb,
	output logic                  wr_start,
	output nand_pkg::cycle_kind_t wr_kind,
	output logic [7:0]            wr_byte,
	input  logic                  wr_done,
	output logic                  rd_start,
	input  logic [7:0]            rd_byte,
	input  logic                  rd_done
);

	localparam logic [2:0] ID_LAST = 3'(nand_pkg::ID_BYTES - 1);
	localparam logic [2:0] ID_END = 3'(nand_pkg::ID_BYTES);

	nand_pkg::seq_state_t state;
	nand_pkg::host_op_t   op_q;

	// Countdown for tWB and tWHR
	logic [3:0] wait_cnt;

	// Controller status, see ST_* bit positions
	logic [7:0] status;

	// ID buffer and its index, the index also fills the buffer
	logic [7:0] id_buf [nand_pkg::ID_BYTES];
	logic [2:0] id_index;

	//----------------------------
	// Main FSM
	//----------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			state    <= nand_pkg::S_IDLE;
			op_q     <= nand_pkg::OP_GET_STATUS;
			wr_kind  <= nand_pkg::CYC_CMD;
			wait_cnt <= '0;
			id_index <= '0;
			status   <= nand_pkg::STATUS_RESET;
		end else begin
			case (state)
			nand_pkg::S_IDLE: begin
				if (activate) begin
					op_q <= cmd_in;
					case (cmd_in)
					nand_pkg::OP_NAND_RESET: begin
						wr_kind <= nand_pkg::CYC_CMD;
						wr_byte <= nand_pkg::NAND_CMD_RESET;
						state   <= nand_pkg::S_WRITE;
					end
					nand_pkg::OP_READ_STATUS: begin
						wr_kind <= nand_pkg::CYC_CMD;
						wr_byte <= nand_pkg::NAND_CMD_READ_STATUS;
						state   <= nand_pkg::S_WRITE;
					end
					nand_pkg::OP_READ_ID: begin
						wr_kind  <= nand_pkg::CYC_CMD;
						wr_byte  <= nand_pkg::NAND_CMD_READ_ID;
						id_index <= '0;
						state    <= nand_pkg::S_WRITE;
					end
					// Raw cycles take their byte from data_in
					nand_pkg::OP_BYPASS_COMMAND: begin
						wr_kind <= nand_pkg::CYC_CMD;
						wr_byte <= data_in;
						state   <= nand_pkg::S_WRITE;
					end
					nand_pkg::OP_BYPASS_ADDRESS: begin
						wr_kind <= nand_pkg::CYC_ADDR;
						wr_byte <= data_in;
						state   <= nand_pkg::S_WRITE;
					end
					nand_pkg::OP_BYPASS_DATA_WR: begin
						wr_kind <= nand_pkg::CYC_DATA;
						wr_byte <= data_in;
						state   <= nand_pkg::S_WRITE;
					end
					nand_pkg::OP_BYPASS_DATA_RD:
						state <= nand_pkg::S_READ;
					// Register ops finish in one busy cycle
					default:
						state <= nand_pkg::S_REG;
					endcase
				end
			end

			nand_pkg::S_REG: begin
				case (op_q)
				nand_pkg::OP_GET_STATUS:
					data_out <= status;
				nand_pkg::OP_CHIP_ENABLE:
					status[nand_pkg::ST_CHIP_EN] <= 1'b1;
				nand_pkg::OP_CHIP_DISABLE:
					status[nand_pkg::ST_CHIP_EN] <= 1'b0;
				nand_pkg::OP_WRITE_PROTECT:
					status[nand_pkg::ST_WRITE_PROT] <= 1'b1;
				nand_pkg::OP_WRITE_ENABLE:
					status[nand_pkg::ST_WRITE_PROT] <= 1'b0;
				nand_pkg::OP_RESET_INDEX:
					id_index <= '0;
				nand_pkg::OP_GET_ID_BYTE: begin
					if (id_index < ID_END) begin
						data_out <= id_buf[id_index];
						id_index <= id_index + 3'd1;
						status[nand_pkg::ST_INDEX_ERR] <= 1'b0;
					end else begin
						// Past the end, wrap and flag it
						data_out <= 8'h00;
						id_index <= '0;
						status[nand_pkg::ST_INDEX_ERR] <= 1'b1;
					end
				end
				default: ;
				endcase
				state <= nand_pkg::S_IDLE;
			end

			// wr_start is high in this state only
			nand_pkg::S_WRITE:
				state <= nand_pkg::S_WR_WAIT;

			nand_pkg::S_WR_WAIT: begin
				if (wr_done) begin
					if (op_q == nand_pkg::OP_READ_ID && wr_kind == nand_pkg::CYC_CMD) begin
						// READ ID address cycle
						wr_kind <= nand_pkg::CYC_ADDR;
						wr_byte <= 8'h00;
						state   <= nand_pkg::S_WRITE;
					end else if (op_q == nand_pkg::OP_NAND_RESET) begin
						wait_cnt <= nand_pkg::T_WB;
						state    <= nand_pkg::S_DELAY;
					end else if (op_q == nand_pkg::OP_READ_STATUS ||
							op_q == nand_pkg::OP_READ_ID) begin
						wait_cnt <= nand_pkg::T_WHR;
						state    <= nand_pkg::S_DELAY;
					end else begin
						state <= nand_pkg::S_IDLE;
					end
				end
			end

			// Counts exactly wait_cnt clocks
			nand_pkg::S_DELAY: begin
				if (wait_cnt > 4'd1)
					wait_cnt <= wait_cnt - 4'd1;
				else if (op_q == nand_pkg::OP_NAND_RESET)
					state <= nand_pkg::S_RNB;
				else
					state <= nand_pkg::S_READ;
			end

			// Chip busy after RESET
			nand_pkg::S_RNB: begin
				if (rnb)
					state <= nand_pkg::S_IDLE;
			end

			// rd_start is high in this state only
			nand_pkg::S_READ:
				state <= nand_pkg::S_RD_WAIT;

			nand_pkg::S_RD_WAIT: begin
				if (rd_done) begin
					if (op_q == nand_pkg::OP_READ_ID) begin
						id_buf[id_index] <= rd_byte;
						if (id_index == ID_LAST) begin
							id_index <= '0;
							state    <= nand_pkg::S_IDLE;
						end else begin
							id_index <= id_index + 3'd1;
							state    <= nand_pkg::S_READ;
						end
					end else begin
						// READ STATUS and bypass read
						data_out <= rd_byte;
						state    <= nand_pkg::S_IDLE;
					end
				end
			end

			default:
				state <= nand_pkg::S_IDLE;
			endcase
		end
	end

	//----------------------------
	// Outputs
	//----------------------------
	assign busy     = (state != nand_pkg::S_IDLE);
	assign wr_start = (state == nand_pkg::S_WRITE);
	assign rd_start = (state == nand_pkg::S_READ);

	// Pin levels follow the status bits, both active low
	assign nce = ~status[nand_pkg::ST_CHIP_EN];
	assign nwp = ~status[nand_pkg::ST_WRITE_PROT];

endmodule

// ==== rtl/nand_master.sv ====
//----------------------------
// ONFI NAND master, x8, split data bus
// Tristate buffer for DQ sits outside, enabled by nand_dq_oe
//----------------------------
module nand_master (
	input  logic               clk,
	input  logic               nreset,
	input  logic               activate,
	input  nand_pkg::host_op_t cmd_in,
	input  logic [7:0]         data_in,
	output logic [7:0]         data_out,
	output logic               busy,
	output logic               nand_cle,
	output logic               nand_ale,
	output logic               nand_nwe,
	output logic               nand_nre,
	output logic               nand_nce,
	output logic               nand_nwp,
	input  logic               nand_rnb,
	output logic [7:0]         nand_dq_out,
	output logic               nand_dq_oe,
	input  logic [7:0]         nand_dq_in
);

	// Sequencer to cycle units
	logic                  wr_start;
	nand_pkg::cycle_kind_t wr_kind;
	logic [7:0]            wr_byte;
	logic                  wr_done;
	logic                  rd_start;
	logic [7:0]            rd_byte;
	logic                  rd_done;

	nand_sequencer u_sequencer (
		.clk(clk), .nreset(nreset), .activate(activate), .cmd_in(cmd_in),
		.data_in(data_in), .data_out(data_out), .busy(busy),
		.nce(nand_nce), .nwp(nand_nwp), .rnb(nand_rnb),
		.wr_start(wr_start), .wr_kind(wr_kind), .wr_byte(wr_byte), .wr_done(wr_done),
		.rd_start(rd_start), .rd_byte(rd_byte), .rd_done(rd_done)
	);

	nand_write_cycle u_write_cycle (
		.clk(clk), .nreset(nreset), .start(wr_start), .kind(wr_kind), .data(wr_byte),
		.done(wr_done), .cle(nand_cle), .ale(nand_ale), .nwe(nand_nwe),
		.dq_out(nand_dq_out), .dq_oe(nand_dq_oe)
	);

	nand_read_cycle u_read_cycle (
		.clk(clk), .nreset(nreset), .start(rd_start), .dq_in(nand_dq_in),
		.done(rd_done), .nre(nand_nre), .data(rd_byte)
	);

endmodule

// ==== verif/nand_model.sv ====
//----------------------------
// Behavioural x8 NAND chip, split DQ bus
// Cycles are taken on rising WE#/RE# and only while CE# is low
//----------------------------
module nand_model (
	input  logic       clk,
	input  logic       nreset,
	input  logic       nce,
	input  logic       cle,
	input  logic       ale,
	input  logic       nwe,
	input  logic       nre,
	input  logic       nwp,
	input  logic [7:0] dq_in,
	output logic [7:0] dq_out,
	output logic       rnb
);

	localparam int LOG_DEPTH = 256;
	localparam int RESET_BUSY = 20;

	// What the next read returns
	localparam int MODE_ECHO = 0;
	localparam int MODE_STATUS = 1;
	localparam int MODE_ID = 2;

	// Log of latched write cycles, read by the testbench
	nand_pkg::cycle_kind_t log_kind [LOG_DEPTH];
	logic [7:0]            log_byte [LOG_DEPTH];
	int                    log_count;

	int       busy_cnt;
	int       mode;
	int       id_ptr;
	bit       id_pending;
	bit [7:0] echo_byte;
	logic     nwe_q;
	logic     nre_q;

	// Fixed JEDEC-style ID
	function automatic logic [7:0] id_byte(input int idx);
		case (idx)
		0: id_byte = 8'h2c;
		1: id_byte = 8'hdc;
		2: id_byte = 8'h90;
		3: id_byte = 8'h95;
		4: id_byte = 8'h56;
		default: id_byte = 8'h00;
		endcase
	endfunction

	always @(posedge clk) begin
		nwe_q <= nwe;
		nre_q <= nre;
		if (!nreset) begin
			log_count  <= 0;
			busy_cnt   <= 0;
			mode       <= MODE_ECHO;
			id_ptr     <= 0;
			id_pending <= 1'b0;
			echo_byte  <= 8'h00;
		end else begin
			if (busy_cnt > 0)
				busy_cnt <= busy_cnt - 1;
			// Rising WE#, CLE/ALE and DQ still held by the master
			if (nwe && !nwe_q && !nce) begin
				if (log_count < LOG_DEPTH) begin
					log_kind[log_count[7:0]] <= cle ? nand_pkg::CYC_CMD :
						ale ? nand_pkg::CYC_ADDR : nand_pkg::CYC_DATA;
					log_byte[log_count[7:0]] <= dq_in;
				end
				log_count <= log_count + 1;
				if (cle) begin
					id_pending <= (dq_in == nand_pkg::NAND_CMD_READ_ID);
					mode       <= (dq_in == nand_pkg::NAND_CMD_READ_STATUS) ? MODE_STATUS : MODE_ECHO;
					// RESET keeps R/B# low for a while
					if (dq_in == nand_pkg::NAND_CMD_RESET)
						busy_cnt <= RESET_BUSY;
				end else if (ale) begin
					if (id_pending && dq_in == 8'h00) begin
						mode   <= MODE_ID;
						id_ptr <= 0;
					end
					id_pending <= 1'b0;
				end else begin
					echo_byte <= dq_in;
					mode      <= MODE_ECHO;
				end
			end
			// Rising RE# steps through the ID
			if (nre && !nre_q && !nce && mode == MODE_ID)
				id_ptr <= id_ptr + 1;
		end
	end

	// Read data, bit 7 of status is the WP# level
	always_comb begin
		case (mode)
		MODE_STATUS: dq_out = {nwp, 7'h40};
		MODE_ID:     dq_out = id_byte(id_ptr);
		default:     dq_out = echo_byte ^ 8'ha5;
		endcase
	end

	assign rnb = (busy_cnt == 0);

endmodule

// ==== verif/nand_master_chk.sv ====
//----------------------------
// NAND pin protocol checks, bound into nand_master
//----------------------------
module nand_master_chk (
	input logic       clk,
	input logic       nreset,
	input logic       nand_cle,
	input logic       nand_ale,
	input logic       nand_nwe,
	input logic       nand_nre,
	input logic [7:0] nand_dq_out,
	input logic       nand_dq_oe
);

	// Count of failed assertions
	int fail_count = 0;

	// Write and read strobes exclusive
	we_re_apart: assert property (@(posedge clk) disable iff (!nreset)
		!(!nand_nwe && !nand_nre))
		else begin
			$error("WE# and RE# low together");
			fail_count++;
		end

	// Command and address latch exclusive
	cle_ale_apart: assert property (@(posedge clk) disable iff (!nreset)
		!(nand_cle && nand_ale))
		else begin
			$error("CLE and ALE high together");
			fail_count++;
		end

	// Latch inputs held through the WE# low phase
	we_low_stable: assert property (@(posedge clk) disable iff (!nreset)
		(!nand_nwe && !$past(nand_nwe)) |->
			($stable(nand_cle) && $stable(nand_ale) && $stable(nand_dq_out)))
		else begin
			$error("CLE, ALE or DQ changed while WE# was low");
			fail_count++;
		end

	// Master drives DQ while WE# is low
	we_low_driven: assert property (@(posedge clk) disable iff (!nreset)
		!nand_nwe |-> nand_dq_oe)
		else begin
			$error("DQ not driven while WE# was low");
			fail_count++;
		end

	// No bus fight while the chip drives DQ
	re_low_no_drive: assert property (@(posedge clk) disable iff (!nreset)
		!nand_nre |-> !nand_dq_oe)
		else begin
			$error("DQ driven while RE# was low");
			fail_count++;
		end

endmodule

// ==== verif/tb_nand_master.sv ====
//----------------------------
// Directed testbench for nand_master with a behavioural chip
// Inputs change on the falling clock edge
//----------------------------
module tb_nand_master;

	// Max busy cycles of one opcode
	localparam int OP_TIMEOUT = 200;

	logic               clk;
	logic               nreset;
	logic               activate;
	nand_pkg::host_op_t cmd_in;
	logic [7:0]         data_in;
	logic [7:0]         data_out;
	logic               busy;
	logic               nand_cle;
	logic               nand_ale;
	logic               nand_nwe;
	logic               nand_nre;
	logic               nand_nce;
	logic               nand_nwp;
	logic               nand_rnb;
	logic [7:0]         nand_dq_out;
	logic               nand_dq_oe;
	logic [7:0]         nand_dq_in;

	logic [31:0] rng_state;

	nand_master u_nand_master (
		.clk(clk), .nreset(nreset), .activate(activate), .cmd_in(cmd_in),
		.data_in(data_in), .data_out(data_out), .busy(busy),
		.nand_cle(nand_cle), .nand_ale(nand_ale), .nand_nwe(nand_nwe), .nand_nre(nand_nre),
		.nand_nce(nand_nce), .nand_nwp(nand_nwp), .nand_rnb(nand_rnb),
		.nand_dq_out(nand_dq_out), .nand_dq_oe(nand_dq_oe), .nand_dq_in(nand_dq_in)
	);

	nand_model u_model (
		.clk(clk), .nreset(nreset), .nce(nand_nce), .cle(nand_cle), .ale(nand_ale),
		.nwe(nand_nwe), .nre(nand_nre), .nwp(nand_nwp), .dq_in(nand_dq_out),
		.dq_out(nand_dq_in), .rnb(nand_rnb)
	);

	bind nand_master nand_master_chk u_chk (
		.clk(clk), .nreset(nreset), .nand_cle(nand_cle), .nand_ale(nand_ale),
		.nand_nwe(nand_nwe), .nand_nre(nand_nre), .nand_dq_out(nand_dq_out),
		.nand_dq_oe(nand_dq_oe)
	);

	always #50 clk = ~clk;

	//----------------------------
	// Helpers
	//----------------------------
	task automatic error_stop(input string msg);
		$display("Error: %0t: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic timeout_stop(input string msg);
		$display("Timeout at %0t: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// The five ID bytes the chip is known to return
	function automatic logic [7:0] expected_id(input int idx);
		case (idx)
		0: expected_id = 8'h2c;
		1: expected_id = 8'hdc;
		2: expected_id = 8'h90;
		3: expected_id = 8'h95;
		default: expected_id = 8'h56;
		endcase
	endfunction

	// Status byte from the individual flags
	function automatic logic [7:0] status_expect(input bit en, input bit wp, input bit idx_err);
		logic [7:0] s;
		s = 8'h00;
		s[nand_pkg::ST_CHIP_EN] = en;
		s[nand_pkg::ST_WRITE_PROT] = wp;
		s[nand_pkg::ST_INDEX_ERR] = idx_err;
		return s;
	endfunction

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else error_stop($sformatf("%s is %02h, expected %02h", what, got, exp));
	endtask

	task automatic check_pin(input string what, input logic got, input logic exp);
		assert (got === exp)
		else error_stop($sformatf("%s pin is %b, expected %b", what, got, exp));
	endtask

	// Pulse activate, then count busy cycles until it falls
	task automatic issue_op(input nand_pkg::host_op_t op, input logic [7:0] value,
			output int cycles, output bit saw_rnb_low);
		@(negedge clk);
		cmd_in = op;
		data_in = value;
		activate = 1'b1;
		@(negedge clk);
		activate = 1'b0;
		cycles = 0;
		saw_rnb_low = 1'b0;
		while (busy) begin
			if (!nand_rnb)
				saw_rnb_low = 1'b1;
			cycles++;
			if (cycles > OP_TIMEOUT)
				timeout_stop("busy did not fall after an opcode");
			@(negedge clk);
		end
	endtask

	task automatic reg_op(input nand_pkg::host_op_t op);
		int cycles;
		bit saw_low;
		issue_op(op, 8'h00, cycles, saw_low);
		assert (cycles == 1)
		else error_stop($sformatf("register opcode held busy for %0d cycles", cycles));
	endtask

	task automatic nand_op(input nand_pkg::host_op_t op, input logic [7:0] value);
		int cycles;
		bit saw_low;
		issue_op(op, value, cycles, saw_low);
		assert (cycles > 1)
		else error_stop("NAND opcode did not keep busy high");
	endtask

	task automatic check_status(input bit en, input bit wp, input bit idx_err);
		reg_op(nand_pkg::OP_GET_STATUS);
		check_byte("status", data_out, status_expect(en, wp, idx_err));
		check_pin("CE#", nand_nce, !en);
		check_pin("WP#", nand_nwp, !wp);
	endtask

	// Compare one entry counted back from the newest in the chip log
	task automatic check_logged(input int back, input nand_pkg::cycle_kind_t kind,
			input logic [7:0] value);
		int idx;
		idx = u_model.log_count - back;
		assert (idx >= 0)
		else error_stop("chip log holds fewer cycles than expected");
		assert (u_model.log_kind[idx[7:0]] == kind)
		else error_stop($sformatf("logged cycle kind is %0d, expected %0d",
			u_model.log_kind[idx[7:0]], kind));
		check_byte("logged byte", u_model.log_byte[idx[7:0]], value);
	endtask

	//----------------------------
	// Directed tests
	//----------------------------
	task automatic test_registers();
		reg_op(nand_pkg::OP_GET_STATUS);
		check_byte("status after reset", data_out, nand_pkg::STATUS_RESET);
		check_pin("CE#", nand_nce, 1'b1);
		check_pin("WP#", nand_nwp, 1'b0);
		reg_op(nand_pkg::OP_CHIP_ENABLE);
		reg_op(nand_pkg::OP_WRITE_ENABLE);
		check_status(1'b1, 1'b0, 1'b0);
		reg_op(nand_pkg::OP_WRITE_PROTECT);
		reg_op(nand_pkg::OP_CHIP_DISABLE);
		check_status(1'b0, 1'b1, 1'b0);
	endtask

	task automatic test_read_id();
		reg_op(nand_pkg::OP_CHIP_ENABLE);
		nand_op(nand_pkg::OP_READ_ID, 8'h00);
		check_logged(2, nand_pkg::CYC_CMD, 8'h90);
		check_logged(1, nand_pkg::CYC_ADDR, 8'h00);
		for (int i = 0; i < nand_pkg::ID_BYTES; i++) begin
			reg_op(nand_pkg::OP_GET_ID_BYTE);
			check_byte("ID byte", data_out, expected_id(i));
		end
		// One past the end reads zero and flags it
		reg_op(nand_pkg::OP_GET_ID_BYTE);
		check_byte("ID byte past end", data_out, 8'h00);
		check_status(1'b1, 1'b1, 1'b1);
		reg_op(nand_pkg::OP_RESET_INDEX);
		reg_op(nand_pkg::OP_GET_ID_BYTE);
		check_byte("first ID byte again", data_out, expected_id(0));
		check_status(1'b1, 1'b1, 1'b0);
	endtask

	task automatic test_nand_reset();
		int cycles;
		bit saw_low;
		issue_op(nand_pkg::OP_NAND_RESET, 8'h00, cycles, saw_low);
		check_logged(1, nand_pkg::CYC_CMD, 8'hff);
		assert (saw_low)
		else error_stop("R/B# never went low while busy was high");
		assert (nand_rnb)
		else error_stop("busy fell while R/B# was still low");
	endtask

	// Chip status is 40h with bit 7 following WP#
	task automatic test_read_status();
		reg_op(nand_pkg::OP_WRITE_ENABLE);
		nand_op(nand_pkg::OP_READ_STATUS, 8'h00);
		check_logged(1, nand_pkg::CYC_CMD, 8'h70);
		check_byte("chip status, unprotected", data_out, 8'hc0);
		reg_op(nand_pkg::OP_WRITE_PROTECT);
		nand_op(nand_pkg::OP_READ_STATUS, 8'h00);
		check_byte("chip status, protected", data_out, 8'h40);
	endtask

	task automatic test_bypass();
		logic [7:0] value;
		logic [7:0] last_data;
		last_data = 8'h00;
		for (int round = 0; round < 4; round++) begin
			rng_state = xorshift32(rng_state);
			value = rng_state[7:0];
			nand_op(nand_pkg::OP_BYPASS_COMMAND, value);
			check_logged(1, nand_pkg::CYC_CMD, value);
			rng_state = xorshift32(rng_state);
			value = rng_state[7:0];
			nand_op(nand_pkg::OP_BYPASS_ADDRESS, value);
			check_logged(1, nand_pkg::CYC_ADDR, value);
			rng_state = xorshift32(rng_state);
			value = rng_state[7:0];
			nand_op(nand_pkg::OP_BYPASS_DATA_WR, value);
			check_logged(1, nand_pkg::CYC_DATA, value);
			last_data = value;
		end
		// Chip echoes the last data byte inverted by A5h
		nand_op(nand_pkg::OP_BYPASS_DATA_RD, 8'h00);
		check_byte("bypass read", data_out, last_data ^ 8'ha5);
		reg_op(nand_pkg::OP_CHIP_DISABLE);
	endtask

	//----------------------------
	// Main sequence
	//----------------------------
	initial begin
		clk = 1'b0;
		nreset = 1'b0;
		activate = 1'b0;
		cmd_in = nand_pkg::OP_GET_STATUS;
		data_in = 8'h00;
		rng_state = 32'd28359;
		repeat (8) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;
		test_registers();
		test_read_id();
		test_nand_reset();
		test_read_status();
		test_bypass();
		// Pin protocol assertions may have failed along the way
		if (u_nand_master.u_chk.fail_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== nand_master.f ====
rtl/nand_pkg.sv
rtl/nand_write_cycle.sv
rtl/nand_read_cycle.sv
rtl/nand_sequencer.sv
rtl/nand_master.sv
verif/nand_model.sv
verif/nand_master_chk.sv
verif/tb_nand_master.sv

// ==== Makefile ====
# Verilator build and run of the nand_master testbench

VERILATOR ?= verilator
TOP       ?= tb_nand_master
RTL_TOP   ?= nand_master
FILELIST  ?= nand_master.f
BUILD     ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RTL_FILES ?= rtl/nand_pkg.sv rtl/nand_write_cycle.sv rtl/nand_read_cycle.sv \
             rtl/nand_sequencer.sv rtl/nand_master.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)
